// ==== bench/axi_slave_model.sv ====
`timescale 1ns/1ps

module axi_slave_model (
    input  logic             aclk,
    input  logic             rst_n_i,

    input  logic             arvalid_i,
    input  axi_pkg::axi_ar_t ar_i,
    output logic             arready_o,
    output logic             rvalid_o,
    output axi_pkg::axi_r_t  r_o,
    input  logic             rready_i,

    input  logic             awvalid_i,
    input  axi_pkg::axi_ar_t aw_i,
    output logic             awready_o,
    input  logic             wvalid_i,
    input  axi_pkg::axi_w_t  w_i,
    output logic             wready_o,
    output logic             bvalid_o,
    output axi_pkg::axi_b_t  b_o,
    input  logic             bready_i
);
    import axi_pkg::*;

    axi_data_t  mem [256];
    logic [1:0] ar_cnt;
    logic [1:0] aw_cnt;
    logic [1:0] w_cnt;
    logic       aw_got;
    logic       w_got;
    axi_ar_t    aw_q;
    axi_w_t     w_q;

    function automatic axi_data_t apply_strobes(input axi_data_t old, input axi_data_t data,
                                                input axi_strb_t strb);
        axi_data_t res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) res[8*i +: 8] = data[8*i +: 8];
        end
        return res;
    endfunction

    // each ready drops for 0 to 3 cycles after its handshake
    assign arready_o = (ar_cnt == 2'd0);
    assign awready_o = (aw_cnt == 2'd0);
    assign wready_o  = (w_cnt == 2'd0);

    always @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 256; i++) begin
                mem[i] <= {8'(i) ^ 8'h5a, ~8'(i), 8'(i), 8'(i) ^ 8'ha5}; // preload
            end
            ar_cnt   <= '0;
            aw_cnt   <= '0;
            w_cnt    <= '0;
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
            aw_q     <= '0;
            w_q      <= '0;
            rvalid_o <= 1'b0;
            bvalid_o <= 1'b0;
            r_o      <= '0;
            b_o      <= '0;
        end else begin
            if (ar_cnt != 2'd0) ar_cnt <= ar_cnt - 2'd1;
            if (aw_cnt != 2'd0) aw_cnt <= aw_cnt - 2'd1;
            if (w_cnt != 2'd0)  w_cnt  <= w_cnt - 2'd1;
            if (rvalid_o && rready_i) rvalid_o <= 1'b0;
            if (bvalid_o && bready_i) bvalid_o <= 1'b0;

            if (arvalid_i && arready_o) begin
                ar_cnt   <= 2'($urandom % 4);
                rvalid_o <= 1'b1;
                r_o      <= '{id: ar_i.id, data: mem[ar_i.addr[7:0]], resp: 2'b00, last: 1'b1};
            end
            if (awvalid_i && awready_o) begin
                aw_cnt <= 2'($urandom % 4);
                aw_got <= 1'b1;
                aw_q   <= aw_i;
            end
            if (wvalid_i && wready_o) begin
                w_cnt <= 2'($urandom % 4);
                w_got <= 1'b1;
                w_q   <= w_i;
            end
            if (aw_got && w_got) begin // both halves of the write are in
                mem[aw_q.addr[7:0]] <= apply_strobes(mem[aw_q.addr[7:0]], w_q.data, w_q.strb);
                aw_got   <= 1'b0;
                w_got    <= 1'b0;
                bvalid_o <= 1'b1;
                b_o      <= '{id: aw_q.id, resp: 2'b00};
            end
        end
    end

endmodule

// ==== bench/tb_soc_bus.sv ====
`timescale 1ns/1ps
`include "soc_defs.svh"

module tb_soc_bus;
    import axi_pkg::*;
    import cpu_mem_pkg::*;

    localparam int RELEASE_TIMEOUT = 100;

    logic      aclk;
    logic      rst_n;
    mem_req_t  inst_req;
    mem_req_t  data_req;
    logic      stall;
    mem_word_t inst_rdata;
    mem_word_t data_rdata;

    logic      arvalid, arready;
    logic      rvalid, rready;
    logic      awvalid, awready;
    logic      wvalid, wready;
    logic      bvalid, bready;
    axi_ar_t   ar;
    axi_r_t    r;
    axi_ar_t   aw;
    axi_w_t    w;
    axi_b_t    b;

    mem_word_t ref_mem [256];
    mem_word_t last_inst;
    mem_word_t last_data;
    logic      data_known; // data port result defined since its last read
    axi_id_t   ar_ids [$];
    axi_addr_t ar_addrs [$];
    axi_id_t   aw_ids [$];
    axi_addr_t aw_addrs [$];
    axi_id_t   w_ids [$];
    logic      w_lasts [$];

    soc_bus_top u_dut (
        .aclk(aclk), .rst_n_i(rst_n),
        .inst_req_i(inst_req), .data_req_i(data_req), .stall_o(stall),
        .inst_rdata_o(inst_rdata), .data_rdata_o(data_rdata),
        .arvalid_o(arvalid), .ar_o(ar), .arready_i(arready),
        .rvalid_i(rvalid), .r_i(r), .rready_o(rready),
        .awvalid_o(awvalid), .aw_o(aw), .awready_i(awready),
        .wvalid_o(wvalid), .w_o(w), .wready_i(wready),
        .bvalid_i(bvalid), .b_i(b), .bready_o(bready)
    );

    axi_slave_model u_slave (
        .aclk(aclk), .rst_n_i(rst_n),
        .arvalid_i(arvalid), .ar_i(ar), .arready_o(arready),
        .rvalid_o(rvalid), .r_o(r), .rready_i(rready),
        .awvalid_i(awvalid), .aw_i(aw), .awready_o(awready),
        .wvalid_i(wvalid), .w_i(w), .wready_o(wready),
        .bvalid_o(bvalid), .b_o(b), .bready_i(bready)
    );

    initial aclk = 1'b0;
    always #4 aclk = ~aclk;

    // handshakes complete at the next rising edge
    always @(negedge aclk) begin
        if (arvalid && arready) begin
            ar_ids.push_back(ar.id);
            ar_addrs.push_back(ar.addr);
        end
        if (awvalid && awready) begin
            aw_ids.push_back(aw.id);
            aw_addrs.push_back(aw.addr);
        end
        if (wvalid && wready) begin
            w_ids.push_back(w.id);
            w_lasts.push_back(w.last);
        end
    end

    task automatic stop_with_error(input string msg);
        $display("ERRORS FOUND");
        $fatal(1, "%s", msg);
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAILED @%0t: %s got %h expected %h", $time, what, got, exp);
        stop_with_error("stopped at first mismatch");
    endtask

    task automatic check_word(input string what, input mem_word_t got, input mem_word_t exp);
        if (got !== exp) report_mismatch(what, got, exp);
    endtask

    task automatic check_id(input string what, input axi_id_t got, input axi_id_t exp);
        if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
    endtask

    task automatic check_addr(input string what, input axi_addr_t got, input axi_addr_t exp);
        if (got !== exp) report_mismatch(what, got, exp);
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
    endtask

    function automatic mem_word_t merge_bytes(input mem_word_t old, input mem_word_t wdata,
                                              input logic [3:0] wen);
        mem_word_t res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (wen[i]) res[8*i +: 8] = wdata[8*i +: 8];
        end
        return res;
    endfunction

    function automatic mem_req_t make_req(input logic en, input logic [3:0] wen,
                                          input logic [7:0] addr, input mem_word_t wdata);
        mem_req_t req;
        req.en    = en;
        req.wen   = wen;
        req.addr  = {24'h0, addr};
        req.wdata = wdata;
        return req;
    endfunction

    task automatic drive_req(input mem_req_t ireq, input mem_req_t dreq);
        @(posedge aclk);
        inst_req <= ireq;
        data_req <= dreq;
    endtask

    task automatic wait_release();
        int n;
        @(negedge aclk);
        check_flag("stall in request cycle", stall, 1'b1);
        n = 0;
        while (stall && n < RELEASE_TIMEOUT) begin
            @(negedge aclk);
            n++;
        end
        if (stall) stop_with_error("timeout waiting for the release cycle with stall_o low");
    endtask

    // updates the reference memory, runs one request set, checks both rdata outputs
    task automatic run_access(input mem_req_t ireq, input mem_req_t dreq);
        logic dwrite;
        dwrite = dreq.en && (dreq.wen != 4'h0);
        if (ireq.en) last_inst = ref_mem[ireq.addr[7:0]];
        if (dreq.en && !dwrite) begin
            last_data  = ref_mem[dreq.addr[7:0]];
            data_known = 1'b1;
        end
        if (dwrite) begin
            ref_mem[dreq.addr[7:0]] = merge_bytes(ref_mem[dreq.addr[7:0]], dreq.wdata, dreq.wen);
            data_known = 1'b0;
        end
        drive_req(ireq, dreq);
        wait_release();
        check_word("fetch data", inst_rdata, last_inst);
        if (data_known) check_word("load data", data_rdata, last_data);
    endtask

    task automatic after_reset();
        @(negedge aclk);
        check_flag("stall after reset", stall, 1'b0);
        check_flag("arvalid after reset", arvalid, 1'b0);
        check_flag("awvalid after reset", awvalid, 1'b0);
        check_flag("wvalid after reset", wvalid, 1'b0);
        check_flag("rready after reset", rready, 1'b0);
        check_flag("bready after reset", bready, 1'b0);
        check_word("inst rdata after reset", inst_rdata, '0);
        check_word("data rdata after reset", data_rdata, '0);
    endtask

    task automatic single_fetch();
        ar_ids.delete();
        ar_addrs.delete();
        run_access(make_req(1'b1, 4'h0, 8'h17, '0), '0);
        if (ar_ids.size() != 1) stop_with_error("fetch did not give exactly one AR handshake");
        check_id("fetch arid", ar_ids[0], axi_id_t'(`SOC_ID_INST));
        check_addr("fetch araddr", ar_addrs[0], 32'h17);
    endtask

    task automatic store_then_load();
        aw_ids.delete();
        aw_addrs.delete();
        w_ids.delete();
        w_lasts.delete();
        run_access('0, make_req(1'b1, 4'b0101, 8'h42, 32'hdeadbeef));
        if (aw_ids.size() != 1) stop_with_error("store did not give exactly one AW handshake");
        check_id("store awid", aw_ids[0], axi_id_t'(`SOC_ID_DATA));
        check_addr("store awaddr", aw_addrs[0], 32'h42);
        if (w_ids.size() != 1) stop_with_error("store did not give exactly one W handshake");
        check_id("store wid", w_ids[0], axi_id_t'(`SOC_ID_DATA));
        check_flag("store wlast", w_lasts[0], 1'b1);
        run_access('0, make_req(1'b1, 4'h0, 8'h42, '0));
    endtask

    task automatic fetch_with_load();
        ar_ids.delete();
        run_access(make_req(1'b1, 4'h0, 8'h10, '0), make_req(1'b1, 4'h0, 8'h80, '0));
        if (ar_ids.size() != 2) stop_with_error("fetch with load did not give two AR handshakes");
        check_id("first arid", ar_ids[0], axi_id_t'(`SOC_ID_INST));
        check_id("second arid", ar_ids[1], axi_id_t'(`SOC_ID_DATA));
        run_access(make_req(1'b1, 4'h0, 8'h11, '0), '0); // stall must rise again at once
    endtask

    task automatic random_mix();
        logic [1:0] ports;
        logic [3:0] wen;
        mem_req_t   ireq;
        mem_req_t   dreq;
        for (int k = 0; k < 40; k++) begin
            ports = 2'($urandom_range(1, 3));
            wen   = ($urandom_range(0, 1) == 0) ? 4'h0 : 4'($urandom);
            ireq  = make_req(ports[0], 4'h0, 8'h20 + 8'($urandom_range(0, 15)), '0);
            dreq  = make_req(ports[1], wen, 8'h20 + 8'($urandom_range(0, 15)), $urandom);
            run_access(ireq, dreq);
        end
    endtask

    initial begin
        void'($urandom(78));
        rst_n      = 1'b0;
        inst_req   = '0;
        data_req   = '0;
        last_inst  = '0;
        last_data  = '0;
        data_known = 1'b1;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = {8'(i) ^ 8'h5a, ~8'(i), 8'(i), 8'(i) ^ 8'ha5}; // slave preload
        end
        repeat (3) @(posedge aclk);
        rst_n <= 1'b1;

        after_reset();
        single_fetch();
        store_then_load();
        fetch_with_load();
        random_mix();

        drive_req('0, '0);
        @(negedge aclk);
        check_flag("stall when idle", stall, 1'b0);
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== hw/axi_bus_master.sv ====
`timescale 1ns/1ps

module axi_bus_master (
    input  logic                   aclk,
    input  logic                   rst_n_i,

    input  logic                   cmd_valid_i,
    input  axi_pkg::bus_cmd_t      cmd_i,
    output logic                   cmd_ready_o,
    output logic                   done_o,
    output cpu_mem_pkg::mem_word_t rdata_o,

    output logic                   arvalid_o,
    output axi_pkg::axi_ar_t       ar_o,
    input  logic                   arready_i,

    input  logic                   rvalid_i,
    input  axi_pkg::axi_r_t        r_i,
    output logic                   rready_o,

    output logic                   awvalid_o,
    output axi_pkg::axi_ar_t       aw_o,
    input  logic                   awready_i,

    output logic                   wvalid_o,
    output axi_pkg::axi_w_t        w_o,
    input  logic                   wready_i,

    input  logic                   bvalid_i,
    input  axi_pkg::axi_b_t        b_i,
    output logic                   bready_o
);
    import axi_pkg::*;
    import cpu_mem_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_bwait,
        st_rwait
    } state_t;

    state_t    state_q;
    state_t    state_d;
    bus_cmd_t  cmd_q;
    logic      aw_done_q;
    logic      w_done_q;
    logic      done_q;
    mem_word_t rdata_q;

    logic      ar_fire;
    logic      aw_fire;
    logic      w_fire;
    logic      aw_ok;
    logic      w_ok;
    logic      r_match;
    logic      b_match;

    assign ar_fire = arvalid_o & arready_i;
    assign aw_fire = awvalid_o & awready_i;
    assign w_fire  = wvalid_o & wready_i;
    assign aw_ok   = aw_done_q | aw_fire; // now or in an earlier cycle
    assign w_ok    = w_done_q | w_fire;

    // stray beats with a foreign id are taken and dropped
    assign r_match = rvalid_i & rready_o & (r_i.id == cmd_q.id) & r_i.last;
    assign b_match = bvalid_i & bready_o & (b_i.id == cmd_q.id);

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle:  if (cmd_valid_i) state_d = st_addr;
            st_addr: begin
                if (cmd_q.write) begin
                    if (aw_ok && w_ok) state_d = st_bwait;
                end else if (ar_fire) begin
                    state_d = st_rwait;
                end
            end
            st_bwait: if (b_match) state_d = st_idle;
            st_rwait: if (r_match) state_d = st_idle;
            default:  state_d = st_idle;
        endcase
    end

    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= st_idle;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= r_match | b_match; // one cycle after the response
            if (state_q != st_addr || (aw_ok && w_ok)) begin
                aw_done_q <= 1'b0;
                w_done_q  <= 1'b0;
            end else begin
                if (aw_fire) aw_done_q <= 1'b1;
                if (w_fire)  w_done_q  <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (cmd_valid_i && cmd_ready_o) cmd_q <= cmd_i; // held for the whole transfer
        if (r_match) rdata_q <= r_i.data;
    end

    assign cmd_ready_o = (state_q == st_idle);
    assign done_o      = done_q;
    assign rdata_o     = rdata_q;

    assign arvalid_o = (state_q == st_addr) & ~cmd_q.write;
    assign awvalid_o = (state_q == st_addr) & cmd_q.write & ~aw_done_q;
    assign wvalid_o  = (state_q == st_addr) & cmd_q.write & ~w_done_q;
    assign rready_o  = (state_q == st_rwait);
    assign bready_o  = (state_q == st_bwait);

    assign ar_o = '{id: cmd_q.id, addr: cmd_q.addr};
    assign aw_o = '{id: cmd_q.id, addr: cmd_q.addr};
    assign w_o  = '{id: cmd_q.id, data: cmd_q.wdata, strb: cmd_q.wstrb, last: 1'b1};

endmodule

// ==== hw/axi_pkg.sv ====
`include "soc_defs.svh"

package axi_pkg;

    typedef logic [`SOC_ID_W-1:0]   axi_id_t;
    typedef logic [`SOC_ADDR_W-1:0] axi_addr_t;
    typedef logic [`SOC_DATA_W-1:0] axi_data_t;
    typedef logic [`SOC_STRB_W-1:0] axi_strb_t;
    typedef logic [1:0]             axi_resp_t;

    // address channel, shared by ar and aw
    typedef struct packed {
        axi_id_t   id;
        axi_addr_t addr;
    } axi_ar_t;

    typedef struct packed {
        axi_id_t   id;   // same as awid
        axi_data_t data;
        axi_strb_t strb;
        logic      last; // single beat
    } axi_w_t;

    typedef struct packed {
        axi_id_t   id;
        axi_data_t data;
        axi_resp_t resp;
        logic      last;
    } axi_r_t;

    typedef struct packed {
        axi_id_t   id;
        axi_resp_t resp;
    } axi_b_t;

    // one transfer handed from the arbiter to the master
    typedef struct packed {
        logic      write;
        axi_id_t   id;
        axi_addr_t addr;
        axi_data_t wdata;
        axi_strb_t wstrb;
    } bus_cmd_t;

endpackage

// ==== hw/cpu_mem_pkg.sv ====
`include "soc_defs.svh"

package cpu_mem_pkg;

    typedef logic [`SOC_DATA_W-1:0] mem_word_t;

    // one core port, rom or ram side
    typedef struct packed {
        logic                   en;    // access requested
        logic [`SOC_STRB_W-1:0] wen;   // zero means read
        logic [`SOC_ADDR_W-1:0] addr;
        mem_word_t              wdata;
    } mem_req_t;

endpackage

// ==== hw/mem_arbiter.sv ====
`timescale 1ns/1ps
`include "soc_defs.svh"

module mem_arbiter (
    input  logic                   aclk,
    input  logic                   rst_n_i,

    input  cpu_mem_pkg::mem_req_t  inst_req_i,
    input  cpu_mem_pkg::mem_req_t  data_req_i,
    output logic                   stall_o,
    output cpu_mem_pkg::mem_word_t inst_rdata_o,
    output cpu_mem_pkg::mem_word_t data_rdata_o,

    output logic                   cmd_valid_o,
    output axi_pkg::bus_cmd_t      cmd_o,
    input  logic                   cmd_ready_i,
    input  logic                   done_i,
    input  cpu_mem_pkg::mem_word_t rdata_i
);
    import axi_pkg::*;
    import cpu_mem_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_inst,
        st_data,
        st_release
    } state_t;

    state_t    state_q;
    state_t    state_d;
    logic      issued_q;    // command of the current port handed over
    logic      pend_data_q; // data port still to serve after the fetch
    mem_word_t inst_rdata_q;
    mem_word_t data_rdata_q;

    mem_req_t  sel_req;
    logic      serving;
    logic      data_sel;
    logic      data_write;
    logic      cmd_fire;
    logic      cmd_done;

    assign data_sel   = (state_q == st_data);
    assign serving    = (state_q == st_inst) | data_sel;
    assign data_write = |data_req_i.wen;
    assign sel_req    = data_sel ? data_req_i : inst_req_i;
    assign cmd_fire   = cmd_valid_o & cmd_ready_i;
    assign cmd_done   = done_i & issued_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (inst_req_i.en)      state_d = st_inst; // fetch goes first
                else if (data_req_i.en) state_d = st_data;
            end
            st_inst: begin
                if (cmd_done) state_d = pend_data_q ? st_data : st_release;
            end
            st_data:    if (cmd_done) state_d = st_release;
            st_release: state_d = st_idle;
            default:    state_d = st_idle;
        endcase
    end

    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= st_idle;
            issued_q     <= 1'b0;
            pend_data_q  <= 1'b0;
            inst_rdata_q <= '0;
            data_rdata_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == st_idle) pend_data_q <= data_req_i.en;

            if (cmd_fire)      issued_q <= 1'b1;
            else if (cmd_done) issued_q <= 1'b0;

            if (cmd_done && !data_sel) inst_rdata_q <= rdata_i;
            if (cmd_done && data_sel && !data_write) data_rdata_q <= rdata_i;
        end
    end

    // one command per served port
    always_comb begin
        cmd_o       = '0;
        cmd_o.write = data_sel & data_write;
        cmd_o.id    = data_sel ? axi_id_t'(`SOC_ID_DATA) : axi_id_t'(`SOC_ID_INST);
        cmd_o.addr  = sel_req.addr;
        cmd_o.wdata = sel_req.wdata;
        cmd_o.wstrb = cmd_o.write ? sel_req.wen : '0;
    end

    assign cmd_valid_o = serving & ~issued_q;

    always_comb begin
        case (state_q)
            st_idle:    stall_o = inst_req_i.en | data_req_i.en;
            st_release: stall_o = 1'b0; // results valid this cycle
            default:    stall_o = 1'b1;
        endcase
    end

    assign inst_rdata_o = inst_rdata_q;
    assign data_rdata_o = data_rdata_q;

endmodule

// ==== hw/soc_bus_top.sv ====
`timescale 1ns/1ps

module soc_bus_top (
    input  logic                   aclk,
    input  logic                   rst_n_i,

    input  cpu_mem_pkg::mem_req_t  inst_req_i,
    input  cpu_mem_pkg::mem_req_t  data_req_i,
    output logic                   stall_o,
    output cpu_mem_pkg::mem_word_t inst_rdata_o,
    output cpu_mem_pkg::mem_word_t data_rdata_o,

    output logic                   arvalid_o,
    output axi_pkg::axi_ar_t       ar_o,
    input  logic                   arready_i,
    input  logic                   rvalid_i,
    input  axi_pkg::axi_r_t        r_i,
    output logic                   rready_o,
    output logic                   awvalid_o,
    output axi_pkg::axi_ar_t       aw_o,
    input  logic                   awready_i,
    output logic                   wvalid_o,
    output axi_pkg::axi_w_t        w_o,
    input  logic                   wready_i,
    input  logic                   bvalid_i,
    input  axi_pkg::axi_b_t        b_i,
    output logic                   bready_o
);
    import axi_pkg::*;
    import cpu_mem_pkg::*;

    logic      cmd_valid;
    bus_cmd_t  cmd;
    logic      cmd_ready;
    logic      done;
    mem_word_t rdata;

    mem_arbiter u_arbiter (
        .aclk         (aclk),
        .rst_n_i      (rst_n_i),
        .inst_req_i   (inst_req_i),
        .data_req_i   (data_req_i),
        .stall_o      (stall_o),
        .inst_rdata_o (inst_rdata_o),
        .data_rdata_o (data_rdata_o),
        .cmd_valid_o  (cmd_valid),
        .cmd_o        (cmd),
        .cmd_ready_i  (cmd_ready),
        .done_i       (done),
        .rdata_i      (rdata)
    );

    axi_bus_master u_axi_master (
        .aclk        (aclk),
        .rst_n_i     (rst_n_i),
        .cmd_valid_i (cmd_valid),
        .cmd_i       (cmd),
        .cmd_ready_o (cmd_ready),
        .done_o      (done),
        .rdata_o     (rdata),
        .arvalid_o   (arvalid_o),
        .ar_o        (ar_o),
        .arready_i   (arready_i),
        .rvalid_i    (rvalid_i),
        .r_i         (r_i),
        .rready_o    (rready_o),
        .awvalid_o   (awvalid_o),
        .aw_o        (aw_o),
        .awready_i   (awready_i),
        .wvalid_o    (wvalid_o),
        .w_o         (w_o),
        .wready_i    (wready_i),
        .bvalid_i    (bvalid_i),
        .b_i         (b_i),
        .bready_o    (bready_o)
    );

endmodule

// ==== include/soc_defs.svh ====
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32
`define SOC_STRB_W 4 // one enable per byte lane

// axi ids
`define SOC_ID_W 4

// fixed id per core port, fetch and load/store
`define SOC_ID_INST 0
`define SOC_ID_DATA 1

`endif

// ==== list.f ====
+incdir+include
hw/cpu_mem_pkg.sv
hw/axi_pkg.sv
hw/axi_bus_master.sv
hw/mem_arbiter.sv
hw/soc_bus_top.sv
bench/axi_slave_model.sv
bench/tb_soc_bus.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_soc_bus -f list.f -o sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi
exit 0
